/* common/cpu_isa_pkg.sv */
// Instruction set definitions: data and address widths, opcode encodings, reset vector
package cpu_isa_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // ------------------------------------------------------------
  // Opcodes kept in this core
  // ------------------------------------------------------------
  // Absolute mode unless noted
  typedef enum logic [7:0] {
    LDA = 8'hAD,
    LDX = 8'hAE,
    LDY = 8'hAC,
    STA = 8'h8D,
    STX = 8'h8E,
    STY = 8'h8C,
    ADC = 8'h6D,
    AND = 8'h2D,
    EOR = 8'h4D,
    CMP = 8'hCD,
    INC = 8'hEE,
    DEC = 8'hCE,
    JMP = 8'h4C,
    // Implied mode
    CLC = 8'h18,
    NOP = 8'hEA
  } opcode_e;

  // Low byte of the reset vector, high byte follows at +1
  localparam addr_t RESET_VECTOR_DEFAULT = 16'hFFFC;

endpackage

/* common/cpu_uarch_pkg.sv */
// Microarchitecture definitions: sequencer states, control word, ALU and memory bus structs
package cpu_uarch_pkg;

  // Sequencer states
  typedef enum logic [3:0] {
    RESET, VECTOR_1, VECTOR_2, FETCH, DECODE,
    ABS_1, ABS_2, ABS_3, ABS_4, HALT
  } state_e;

  // ALU operations, ADD is the idle value
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_INC, ALU_DEC
  } alu_op_e;

  // Address unit action for the current cycle
  typedef enum logic [2:0] {
    HOLD, VEC_MSB, VEC_LOAD, FETCH_NEXT, STEP, OPERAND, JUMP, NEXT_INSTR
  } addr_op_e;

  // Register select, NONE is zero so an all-zero control word is idle
  typedef enum logic [1:0] {
    SEL_NONE, SEL_A, SEL_X, SEL_Y
  } reg_sel_e;

  // ------------------------------------------------------------
  // Control word from the sequencer, 18 bits
  // ------------------------------------------------------------
  typedef struct packed {
    addr_op_e addr_op;
    alu_op_e  alu_op;
    reg_sel_e alu_src;
    logic     alu_from_mem;
    reg_sel_e load_dst;
    reg_sel_e store_src;
    logic     store_alu;
    logic     commit_acc;
    logic     commit_carry;
    logic     clear_carry;
    logic     write_strobe;
  } ctrl_t;

  typedef struct packed {
    cpu_isa_pkg::data_t a;
    cpu_isa_pkg::data_t b;
    alu_op_e            op;
    logic               carry_in;
  } alu_req_t;

  typedef struct packed {
    cpu_isa_pkg::data_t result;
    logic               carry_out;
  } alu_rsp_t;

  // Memory side, 25 bits
  typedef struct packed {
    cpu_isa_pkg::addr_t address;
    cpu_isa_pkg::data_t wr_data;
    logic               wr_enable;
  } mem_req_t;

endpackage

/* core/cpu_alu.sv */
// Combinational ALU: add with carry, compare subtract, AND, XOR, increment, decrement
`timescale 1ns/100ps

module cpu_alu (
  input  cpu_uarch_pkg::alu_req_t alu_req,
  output cpu_uarch_pkg::alu_rsp_t alu_rsp
);

  // Ninth bit carries out of ADD, borrows out of SUB
  logic [8:0] wide;

  always_comb begin
    wide              = '0;
    alu_rsp.result    = '0;
    // Carry passes through unless the op defines it
    alu_rsp.carry_out = alu_req.carry_in;
    case (alu_req.op)
      cpu_uarch_pkg::ALU_ADD: begin
        wide              = 9'(alu_req.a) + 9'(alu_req.b) + 9'(alu_req.carry_in);
        alu_rsp.result    = wide[7:0];
        alu_rsp.carry_out = wide[8];
      end
      // Compare style, carry set when a >= b
      cpu_uarch_pkg::ALU_SUB: begin
        wide              = 9'(alu_req.a) - 9'(alu_req.b);
        alu_rsp.result    = wide[7:0];
        alu_rsp.carry_out = ~wide[8];
      end
      cpu_uarch_pkg::ALU_AND: alu_rsp.result = alu_req.a & alu_req.b;
      cpu_uarch_pkg::ALU_XOR: alu_rsp.result = alu_req.a ^ alu_req.b;
      // Wraps at 0xFF and 0x00
      cpu_uarch_pkg::ALU_INC: alu_rsp.result = alu_req.a + 8'd1;
      cpu_uarch_pkg::ALU_DEC: alu_rsp.result = alu_req.a - 8'd1;
      default: ;
    endcase
  end

endmodule

/* core/cpu_regs.sv */
// Register file: A, X and Y, carry flag, ALU operand latch, store data select
`timescale 1ns/100ps

module cpu_regs (
  input  logic                     clk,
  input  logic                     resetn,
  input  cpu_uarch_pkg::ctrl_t     ctrl,
  input  cpu_isa_pkg::data_t       rd_data,
  input  cpu_uarch_pkg::alu_rsp_t  alu_rsp,
  output cpu_uarch_pkg::alu_req_t  alu_req,
  output cpu_isa_pkg::data_t       store_data
);

  cpu_isa_pkg::data_t      a_q;
  cpu_isa_pkg::data_t      x_q;
  cpu_isa_pkg::data_t      y_q;
  logic                    carry_q;
  cpu_uarch_pkg::alu_req_t alu_req_q;
  logic                    alu_latch;

  // Register read port, shared by ALU source and store source
  function automatic cpu_isa_pkg::data_t pick(cpu_uarch_pkg::reg_sel_e sel,
                                              cpu_isa_pkg::data_t a,
                                              cpu_isa_pkg::data_t x,
                                              cpu_isa_pkg::data_t y);
    case (sel)
      cpu_uarch_pkg::SEL_A: return a;
      cpu_uarch_pkg::SEL_X: return x;
      cpu_uarch_pkg::SEL_Y: return y;
      default:              return '0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // ALU operand latch
  // ------------------------------------------------------------
  assign alu_latch = ctrl.alu_from_mem || (ctrl.alu_src != cpu_uarch_pkg::SEL_NONE);

  // Operand a is a register or the memory byte, b is always the memory byte
  always_ff @(posedge clk) begin
    if (alu_latch) begin
      alu_req_q.a        <= ctrl.alu_from_mem ? rd_data : pick(ctrl.alu_src, a_q, x_q, y_q);
      alu_req_q.b        <= rd_data;
      alu_req_q.op       <= ctrl.alu_op;
      alu_req_q.carry_in <= carry_q;
    end
  end

  assign alu_req = alu_req_q;

  // Architectural registers
  always_ff @(posedge clk) begin
    if (!resetn) begin
      a_q     <= '0;
      x_q     <= '0;
      y_q     <= '0;
      carry_q <= 1'b0;
    end else begin
      if (ctrl.commit_acc) begin
        a_q <= alu_rsp.result;
      end
      case (ctrl.load_dst)
        cpu_uarch_pkg::SEL_A: a_q <= rd_data;
        cpu_uarch_pkg::SEL_X: x_q <= rd_data;
        cpu_uarch_pkg::SEL_Y: y_q <= rd_data;
        default: ;
      endcase
      // CLC wins, never issued together with a commit
      if (ctrl.clear_carry) begin
        carry_q <= 1'b0;
      end else if (ctrl.commit_carry) begin
        carry_q <= alu_rsp.carry_out;
      end
    end
  end

  // ALU result for read-modify-write, otherwise a register
  assign store_data = ctrl.store_alu ? alu_rsp.result : pick(ctrl.store_src, a_q, x_q, y_q);

endmodule

/* core/cpu_addr_unit.sv */
// Address unit: program counter, operand bytes, bus address and write strobe
`timescale 1ns/100ps

module cpu_addr_unit #(
  parameter cpu_isa_pkg::addr_t RESET_VECTOR = cpu_isa_pkg::RESET_VECTOR_DEFAULT
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  cpu_uarch_pkg::ctrl_t    ctrl,
  input  cpu_isa_pkg::data_t      rd_data,
  input  cpu_isa_pkg::data_t      store_data,
  output cpu_uarch_pkg::mem_req_t mem_req
);

  cpu_isa_pkg::addr_t pc;
  cpu_isa_pkg::data_t operand_lsb;
  cpu_isa_pkg::data_t operand_msb;
  // Set once the operand bytes were stepped over, picks the PC increment
  logic               long_instr;
  // High operand byte is on rd_data this cycle
  logic               msb_pending;
  cpu_isa_pkg::addr_t operand_addr;
  cpu_isa_pkg::addr_t next_pc;
  cpu_isa_pkg::addr_t address_q;
  cpu_isa_pkg::data_t wr_data_q;
  logic               wr_enable_q;

  assign operand_addr = {(msb_pending ? rd_data : operand_msb), operand_lsb};
  // Three bytes for absolute mode, one for implied
  assign next_pc = pc + (long_instr ? 16'd3 : 16'd1);

  // ------------------------------------------------------------
  // Address sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      address_q   <= RESET_VECTOR;
      wr_enable_q <= 1'b0;
      long_instr  <= 1'b0;
      msb_pending <= 1'b0;
    end else begin
      wr_enable_q <= ctrl.write_strobe;
      case (ctrl.addr_op)
        // Low vector byte in, point at the high one
        cpu_uarch_pkg::VEC_MSB: begin
          pc[7:0]   <= rd_data;
          address_q <= RESET_VECTOR + 16'd1;
        end
        cpu_uarch_pkg::VEC_LOAD: begin
          pc        <= {rd_data, pc[7:0]};
          address_q <= {rd_data, pc[7:0]};
        end
        cpu_uarch_pkg::FETCH_NEXT: begin
          address_q  <= pc + 16'd1;
          long_instr <= 1'b0;
        end
        // Low operand byte in, point at the high one
        cpu_uarch_pkg::STEP: begin
          operand_lsb <= rd_data;
          address_q   <= pc + 16'd2;
          long_instr  <= 1'b1;
          msb_pending <= 1'b1;
        end
        cpu_uarch_pkg::OPERAND: begin
          if (msb_pending) begin
            operand_msb <= rd_data;
          end
          msb_pending <= 1'b0;
          address_q   <= operand_addr;
        end
        cpu_uarch_pkg::JUMP: begin
          pc          <= operand_addr;
          address_q   <= operand_addr;
          msb_pending <= 1'b0;
        end
        cpu_uarch_pkg::NEXT_INSTR: begin
          pc        <= next_pc;
          address_q <= next_pc;
        end
        default: ;
      endcase
    end
  end

  // Write data follows the strobe
  always_ff @(posedge clk) begin
    if (ctrl.write_strobe) begin
      wr_data_q <= store_data;
    end
  end

  assign mem_req.address   = address_q;
  assign mem_req.wr_data   = wr_data_q;
  assign mem_req.wr_enable = wr_enable_q;

endmodule

/* core/cpu_sequencer.sv */
// Core sequencer: state register, instruction register, opcode decode, control word
`timescale 1ns/100ps

module cpu_sequencer (
  input  logic                 clk,
  input  logic                 resetn,
  input  cpu_isa_pkg::data_t   rd_data,
  output cpu_uarch_pkg::ctrl_t ctrl,
  output logic                 halted
);

  cpu_uarch_pkg::state_e  state;
  cpu_uarch_pkg::state_e  state_next;
  cpu_uarch_pkg::state_e  decode_target;
  cpu_isa_pkg::opcode_e   ir;

  // IR starts as NOP so the first FETCH commits nothing
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= cpu_uarch_pkg::RESET;
      ir    <= cpu_isa_pkg::NOP;
    end else begin
      state <= state_next;
      if (state == cpu_uarch_pkg::FETCH) begin
        ir <= cpu_isa_pkg::opcode_e'(rd_data);
      end
    end
  end

  assign halted = (state == cpu_uarch_pkg::HALT);

  // Addressing mode decode
  always_comb begin
    case (ir)
      cpu_isa_pkg::LDA, cpu_isa_pkg::LDX, cpu_isa_pkg::LDY,
      cpu_isa_pkg::STA, cpu_isa_pkg::STX, cpu_isa_pkg::STY,
      cpu_isa_pkg::ADC, cpu_isa_pkg::AND, cpu_isa_pkg::EOR, cpu_isa_pkg::CMP,
      cpu_isa_pkg::INC, cpu_isa_pkg::DEC, cpu_isa_pkg::JMP:
        decode_target = cpu_uarch_pkg::ABS_1;
      cpu_isa_pkg::CLC, cpu_isa_pkg::NOP:
        decode_target = cpu_uarch_pkg::FETCH;
      // Anything else stops the core
      default:
        decode_target = cpu_uarch_pkg::HALT;
    endcase
  end

  // ------------------------------------------------------------
  // Next state and control word
  // ------------------------------------------------------------
  always_comb begin
    ctrl       = '0;
    state_next = state;
    case (state)
      // Reset lands in RESET, which doubles as the low vector byte step
      cpu_uarch_pkg::RESET: begin
        ctrl.addr_op = cpu_uarch_pkg::VEC_MSB;
        state_next   = cpu_uarch_pkg::VECTOR_2;
      end
      cpu_uarch_pkg::VECTOR_2: begin
        ctrl.addr_op = cpu_uarch_pkg::VEC_LOAD;
        state_next   = cpu_uarch_pkg::FETCH;
      end
      // IR still holds the previous instruction here, so its ALU result lands now
      cpu_uarch_pkg::FETCH: begin
        ctrl.addr_op = cpu_uarch_pkg::FETCH_NEXT;
        state_next   = cpu_uarch_pkg::DECODE;
        case (ir)
          cpu_isa_pkg::ADC: begin
            ctrl.commit_acc   = 1'b1;
            ctrl.commit_carry = 1'b1;
          end
          cpu_isa_pkg::AND, cpu_isa_pkg::EOR: ctrl.commit_acc = 1'b1;
          cpu_isa_pkg::CMP: ctrl.commit_carry = 1'b1;
          cpu_isa_pkg::CLC: ctrl.clear_carry = 1'b1;
          default: ;
        endcase
      end
      cpu_uarch_pkg::DECODE: begin
        state_next = decode_target;
        if (decode_target == cpu_uarch_pkg::ABS_1) begin
          ctrl.addr_op = cpu_uarch_pkg::STEP;
        end else if (decode_target == cpu_uarch_pkg::FETCH) begin
          ctrl.addr_op = cpu_uarch_pkg::NEXT_INSTR;
        end
      end
      // High operand byte on the bus, stores issue their write here
      cpu_uarch_pkg::ABS_1: begin
        ctrl.addr_op = cpu_uarch_pkg::OPERAND;
        state_next   = cpu_uarch_pkg::ABS_2;
        case (ir)
          cpu_isa_pkg::JMP: begin
            ctrl.addr_op = cpu_uarch_pkg::JUMP;
            state_next   = cpu_uarch_pkg::FETCH;
          end
          cpu_isa_pkg::STA: begin
            ctrl.write_strobe = 1'b1;
            ctrl.store_src    = cpu_uarch_pkg::SEL_A;
          end
          cpu_isa_pkg::STX: begin
            ctrl.write_strobe = 1'b1;
            ctrl.store_src    = cpu_uarch_pkg::SEL_X;
          end
          cpu_isa_pkg::STY: begin
            ctrl.write_strobe = 1'b1;
            ctrl.store_src    = cpu_uarch_pkg::SEL_Y;
          end
          default: ;
        endcase
      end
      // Data byte available
      cpu_uarch_pkg::ABS_2: begin
        ctrl.addr_op = cpu_uarch_pkg::NEXT_INSTR;
        state_next   = cpu_uarch_pkg::FETCH;
        case (ir)
          cpu_isa_pkg::LDA: ctrl.load_dst = cpu_uarch_pkg::SEL_A;
          cpu_isa_pkg::LDX: ctrl.load_dst = cpu_uarch_pkg::SEL_X;
          cpu_isa_pkg::LDY: ctrl.load_dst = cpu_uarch_pkg::SEL_Y;
          cpu_isa_pkg::ADC: begin
            ctrl.alu_src = cpu_uarch_pkg::SEL_A;
            ctrl.alu_op  = cpu_uarch_pkg::ALU_ADD;
          end
          cpu_isa_pkg::AND: begin
            ctrl.alu_src = cpu_uarch_pkg::SEL_A;
            ctrl.alu_op  = cpu_uarch_pkg::ALU_AND;
          end
          cpu_isa_pkg::EOR: begin
            ctrl.alu_src = cpu_uarch_pkg::SEL_A;
            ctrl.alu_op  = cpu_uarch_pkg::ALU_XOR;
          end
          cpu_isa_pkg::CMP: begin
            ctrl.alu_src = cpu_uarch_pkg::SEL_A;
            ctrl.alu_op  = cpu_uarch_pkg::ALU_SUB;
          end
          // Read-modify-write keeps the operand address for the write back
          cpu_isa_pkg::INC: begin
            ctrl.addr_op      = cpu_uarch_pkg::HOLD;
            ctrl.alu_from_mem = 1'b1;
            ctrl.alu_op       = cpu_uarch_pkg::ALU_INC;
            state_next        = cpu_uarch_pkg::ABS_3;
          end
          cpu_isa_pkg::DEC: begin
            ctrl.addr_op      = cpu_uarch_pkg::HOLD;
            ctrl.alu_from_mem = 1'b1;
            ctrl.alu_op       = cpu_uarch_pkg::ALU_DEC;
            state_next        = cpu_uarch_pkg::ABS_3;
          end
          default: ;
        endcase
      end
      cpu_uarch_pkg::ABS_3: begin
        ctrl.addr_op      = cpu_uarch_pkg::OPERAND;
        ctrl.write_strobe = 1'b1;
        ctrl.store_alu    = 1'b1;
        state_next        = cpu_uarch_pkg::ABS_4;
      end
      // Write pulse is on the bus now
      cpu_uarch_pkg::ABS_4: begin
        ctrl.addr_op = cpu_uarch_pkg::NEXT_INSTR;
        state_next   = cpu_uarch_pkg::FETCH;
      end
      // HALT holds everything until reset
      default: state_next = cpu_uarch_pkg::HALT;
    endcase
  end

endmodule

/* design/cpu_top.sv */
// Core top level: sequencer, register file, address unit and ALU
`timescale 1ns/100ps

module cpu_top #(
  parameter cpu_isa_pkg::addr_t RESET_VECTOR = cpu_isa_pkg::RESET_VECTOR_DEFAULT
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  cpu_isa_pkg::data_t    rd_data,
  output cpu_uarch_pkg::mem_req_t mem_req,
  output logic                  halted
);

  // Control word, one per cycle
  cpu_uarch_pkg::ctrl_t    ctrl;
  // ALU request from the operand latch and its answer
  cpu_uarch_pkg::alu_req_t alu_req;
  cpu_uarch_pkg::alu_rsp_t alu_rsp;
  // Byte headed for the write data register
  cpu_isa_pkg::data_t      store_data;

  cpu_sequencer u_sequencer (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .ctrl    (ctrl),
    .halted  (halted)
  );

  cpu_regs u_regs (
    .clk        (clk),
    .resetn     (resetn),
    .ctrl       (ctrl),
    .rd_data    (rd_data),
    .alu_rsp    (alu_rsp),
    .alu_req    (alu_req),
    .store_data (store_data)
  );

  cpu_alu u_alu (
    .alu_req (alu_req),
    .alu_rsp (alu_rsp)
  );

  cpu_addr_unit #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_addr_unit (
    .clk        (clk),
    .resetn     (resetn),
    .ctrl       (ctrl),
    .rd_data    (rd_data),
    .store_data (store_data),
    .mem_req    (mem_req)
  );

endmodule

/* bench/tb_cpu_model.svh */
// Reference interpreter producing expected bus writes, and program image builders
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

  // Store into the model memory and queue the expected bus write
  function automatic void record_write(cpu_isa_pkg::addr_t ea, cpu_isa_pkg::data_t v);
    model_mem[ea] = v;
    exp_addr.push_back(ea);
    exp_data.push_back(v);
  endfunction

  // ------------------------------------------------------------
  // Interpreter over the program image
  // ------------------------------------------------------------
  function automatic void model_run(output int icount, output bit halts);
    cpu_isa_pkg::addr_t pc;
    cpu_isa_pkg::addr_t ea;
    logic [7:0]         op;
    logic [7:0]         acc;
    logic [7:0]         xr;
    logic [7:0]         yr;
    logic               c;
    logic [8:0]         sum;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 65536; i++) begin
      model_mem[i] = image[i];
    end
    pc = {image[RESET_VEC + 16'd1], image[RESET_VEC]};
    acc = '0;
    xr = '0;
    yr = '0;
    c = 1'b0;
    icount = 0;
    halts = 1'b0;
    while (!halts && icount < 1000) begin
      op = model_mem[pc];
      // Absolute operand, little endian
      ea = {model_mem[pc + 16'd2], model_mem[pc + 16'd1]};
      icount++;
      pc = pc + 16'd3;
      case (op)
        cpu_isa_pkg::LDA: acc = model_mem[ea];
        cpu_isa_pkg::LDX: xr = model_mem[ea];
        cpu_isa_pkg::LDY: yr = model_mem[ea];
        cpu_isa_pkg::STA: record_write(ea, acc);
        cpu_isa_pkg::STX: record_write(ea, xr);
        cpu_isa_pkg::STY: record_write(ea, yr);
        cpu_isa_pkg::ADC: begin
          sum = 9'(acc) + 9'(model_mem[ea]) + 9'(c);
          acc = sum[7:0];
          c = sum[8];
        end
        cpu_isa_pkg::AND: acc = acc & model_mem[ea];
        cpu_isa_pkg::EOR: acc = acc ^ model_mem[ea];
        // Carry means no borrow
        cpu_isa_pkg::CMP: c = (acc >= model_mem[ea]);
        cpu_isa_pkg::INC: record_write(ea, model_mem[ea] + 8'd1);
        cpu_isa_pkg::DEC: record_write(ea, model_mem[ea] - 8'd1);
        cpu_isa_pkg::JMP: pc = ea;
        cpu_isa_pkg::CLC: begin
          c = 1'b0;
          pc = pc - 16'd2;
        end
        cpu_isa_pkg::NOP: pc = pc - 16'd2;
        default: halts = 1'b1;
      endcase
    end
  endfunction

  // ------------------------------------------------------------
  // Program builders
  // ------------------------------------------------------------
  // Fill pattern over the whole address, vector points at org
  task automatic build_start(input cpu_isa_pkg::addr_t org);
    for (int i = 0; i < 65536; i++) begin
      image[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
    end
    image[RESET_VEC] = org[7:0];
    image[RESET_VEC + 16'd1] = org[15:8];
    pc_w = org;
  endtask

  task automatic put_abs(input cpu_isa_pkg::opcode_e op, input cpu_isa_pkg::addr_t ea);
    image[pc_w] = op;
    image[pc_w + 16'd1] = ea[7:0];
    image[pc_w + 16'd2] = ea[15:8];
    pc_w = pc_w + 16'd3;
  endtask

  task automatic put_raw(input logic [7:0] b);
    image[pc_w] = b;
    pc_w = pc_w + 16'd1;
  endtask

  task automatic put_imp(input cpu_isa_pkg::opcode_e op);
    put_raw(op);
  endtask

  task automatic put_data(input cpu_isa_pkg::addr_t ea);
    image[ea] = 8'($random(seed));
  endtask

`endif

/* bench/tb_cpu.sv */
// Testbench top: clock, reset, memory model, test programs, write comparator, watchdog
`timescale 1ns/100ps

module tb_cpu;

  localparam cpu_isa_pkg::addr_t RESET_VEC = 16'hFFF0;
  localparam int CLK_NS = 40;

  logic                    clk;
  logic                    resetn;
  cpu_isa_pkg::data_t      rd_data;
  cpu_uarch_pkg::mem_req_t mem_req;
  logic                    halted;

  // Program image per test, bus writes go to an overlay tagged with the test number
  logic [7:0] image [0:65535];
  logic [7:0] model_mem [0:65535];
  logic [7:0] wr_mem [0:65535];
  int         wr_tag [0:65535];
  int         test_id;

  cpu_isa_pkg::addr_t exp_addr [$];
  cpu_isa_pkg::data_t exp_data [$];
  int                 wr_count;
  logic               prev_we;
  int                 bus_errors;
  int                 errors;
  int                 tests;
  int                 failed;
  longint             deadline;
  int                 seed;
  cpu_isa_pkg::addr_t pc_w;

  `include "tb_cpu_model.svh"

  cpu_top #(
    .RESET_VECTOR (RESET_VEC)
  ) u_cpu_top (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .mem_req (mem_req),
    .halted  (halted)
  );

  // Combinational read, overlay wins for bytes written in this test
  assign rd_data = (wr_tag[mem_req.address] == test_id) ? wr_mem[mem_req.address]
                                                         : image[mem_req.address];

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // Memory write and compare against the model
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!resetn) begin
      wr_count <= 0;
      prev_we <= 1'b0;
    end else begin
      prev_we <= mem_req.wr_enable;
      if (mem_req.wr_enable) begin
        wr_mem[mem_req.address] <= mem_req.wr_data;
        wr_tag[mem_req.address] <= test_id;
        wr_count <= wr_count + 1;
        if (prev_we) begin
          $display("Write pulse at %0t lasts longer than one cycle", $time);
          bus_errors = bus_errors + 1;
        end
        if (wr_count >= exp_addr.size()) begin
          $display("Unexpected write at %0t to address %h", $time, mem_req.address);
          bus_errors = bus_errors + 1;
        end else begin
          if (mem_req.address != exp_addr[wr_count]) begin
            $display("ERR %0t mem_req.address expected %h got %h", $time,
                     exp_addr[wr_count], mem_req.address);
            bus_errors = bus_errors + 1;
          end
          if (mem_req.wr_data != exp_data[wr_count]) begin
            $display("ERR %0t mem_req.wr_data expected %h got %h", $time,
                     exp_data[wr_count], mem_req.wr_data);
            bus_errors = bus_errors + 1;
          end
        end
      end
    end
  end

  // Watchdog, deadline is moved forward by each test
  initial begin
    forever begin
      #(CLK_NS);
      if ($time > deadline) begin
        $display("Run stopped: the program did not halt in time");
        $display("Simulation failed");
        $finish;
      end
    end
  end

  task automatic run_test(input string name);
    int                 icount;
    bit                 halts;
    int                 err_start;
    cpu_isa_pkg::addr_t vec;
    cpu_isa_pkg::addr_t frozen;
    err_start = errors + bus_errors;
    model_run(icount, halts);
    if (!halts) begin
      $display("Program of test %s never halts in the model", name);
      errors++;
    end
    deadline = $time + longint'((icount * 6 + 80) * CLK_NS);
    vec = {image[RESET_VEC + 16'd1], image[RESET_VEC]};
    @(posedge clk);
    #2;
    resetn = 1'b0;
    test_id = test_id + 1;
    @(posedge clk);
    #2;
    if (mem_req.address != RESET_VEC) begin
      $display("ERR %0t mem_req.address expected %h got %h", $time, RESET_VEC, mem_req.address);
      errors++;
    end
    if (mem_req.wr_enable !== 1'b0) begin
      $display("ERR %0t mem_req.wr_enable expected 0 got %b", $time, mem_req.wr_enable);
      errors++;
    end
    if (halted !== 1'b0) begin
      $display("ERR %0t halted expected 0 got %b", $time, halted);
      errors++;
    end
    @(posedge clk);
    #2;
    resetn = 1'b1;
    @(posedge clk);
    #2;
    if (mem_req.address != RESET_VEC + 16'd1) begin
      $display("ERR %0t mem_req.address expected %h got %h", $time,
               RESET_VEC + 16'd1, mem_req.address);
      errors++;
    end
    @(posedge clk);
    #2;
    // First fetch
    if (mem_req.address != vec) begin
      $display("ERR %0t mem_req.address expected %h got %h", $time, vec, mem_req.address);
      errors++;
    end
    while (halted !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    if (wr_count != exp_addr.size()) begin
      $display("Test %s saw %0d writes where %0d were expected", name, wr_count,
               exp_addr.size());
      errors++;
    end
    // Halt freezes the bus
    frozen = mem_req.address;
    repeat (20) begin
      @(posedge clk);
      #2;
      if (mem_req.address != frozen) begin
        $display("ERR %0t mem_req.address expected %h got %h", $time, frozen, mem_req.address);
        errors++;
      end
      if (mem_req.wr_enable !== 1'b0) begin
        $display("ERR %0t mem_req.wr_enable expected 0 got %b", $time, mem_req.wr_enable);
        errors++;
      end
      if (halted !== 1'b1) begin
        $display("ERR %0t halted expected 1 got %b", $time, halted);
        errors++;
      end
    end
    tests++;
    if (errors + bus_errors == err_start) begin
      $display("Test %s: ok", name);
    end else begin
      failed++;
      $display("Test %s: %0d errors", name, errors + bus_errors - err_start);
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    resetn = 1'b0;
    seed = 3692;
    test_id = 0;
    deadline = 64'd1_000_000;

    build_start(16'h3A50);
    put_raw(8'h02);
    run_test("reset vector");

    build_start(16'h0200);
    for (int i = 0; i < 3; i++) put_data(16'h4000 + 16'(i));
    put_abs(cpu_isa_pkg::LDA, 16'h4000);
    put_abs(cpu_isa_pkg::LDX, 16'h4001);
    put_abs(cpu_isa_pkg::LDY, 16'h4002);
    put_abs(cpu_isa_pkg::STA, 16'h5000);
    put_abs(cpu_isa_pkg::STX, 16'h5001);
    put_abs(cpu_isa_pkg::STY, 16'h5002);
    put_raw(8'h02);
    run_test("loads and stores");

    build_start(16'h0200);
    for (int i = 0; i < 8; i++) put_data(16'h4010 + 16'(i));
    // Large addends so the first ADC before CLC and the one after it both carry
    image[16'h4010] = 8'hF0;
    image[16'h4011] = image[16'h4011] | 8'hC0;
    image[16'h4012] = image[16'h4012] | 8'hC0;
    put_abs(cpu_isa_pkg::LDA, 16'h4010);
    put_abs(cpu_isa_pkg::ADC, 16'h4011);
    // CLC drops the carry of the first ADC
    put_imp(cpu_isa_pkg::CLC);
    put_abs(cpu_isa_pkg::ADC, 16'h4012);
    put_abs(cpu_isa_pkg::ADC, 16'h4013);
    put_abs(cpu_isa_pkg::STA, 16'h5010);
    put_abs(cpu_isa_pkg::AND, 16'h4014);
    put_abs(cpu_isa_pkg::STA, 16'h5011);
    put_abs(cpu_isa_pkg::EOR, 16'h4015);
    put_abs(cpu_isa_pkg::STA, 16'h5012);
    put_abs(cpu_isa_pkg::CMP, 16'h4016);
    put_abs(cpu_isa_pkg::ADC, 16'h4017);
    put_abs(cpu_isa_pkg::STA, 16'h5013);
    put_raw(8'h02);
    run_test("alu operations");

    build_start(16'h0200);
    put_data(16'h4020);
    put_data(16'h4023);
    image[16'h4021] = 8'hFF;
    image[16'h4022] = 8'h00;
    put_abs(cpu_isa_pkg::INC, 16'h4020);
    put_abs(cpu_isa_pkg::DEC, 16'h4023);
    put_abs(cpu_isa_pkg::INC, 16'h4021);
    put_abs(cpu_isa_pkg::DEC, 16'h4022);
    put_abs(cpu_isa_pkg::INC, 16'h4021);
    put_raw(8'h02);
    run_test("read-modify-write");

    build_start(16'h0200);
    put_data(16'h4030);
    put_abs(cpu_isa_pkg::LDA, 16'h4030);
    // Target sits just past the skipped store
    put_abs(cpu_isa_pkg::JMP, pc_w + 16'd6);
    put_abs(cpu_isa_pkg::STA, 16'h5030);
    put_imp(cpu_isa_pkg::NOP);
    put_abs(cpu_isa_pkg::STA, 16'h5031);
    put_abs(cpu_isa_pkg::LDX, 16'h4030);
    put_abs(cpu_isa_pkg::STX, 16'h5032);
    put_raw(8'h02);
    run_test("control flow");

    build_start(16'h0200);
    put_data(16'h4040);
    put_abs(cpu_isa_pkg::LDA, 16'h4040);
    put_abs(cpu_isa_pkg::STA, 16'h5040);
    put_raw(8'hFF);
    put_abs(cpu_isa_pkg::STA, 16'h5041);
    put_raw(8'h02);
    run_test("unknown opcode");

    $display("Tests %0d, failed %0d, errors %0d", tests, failed, errors + bus_errors);
    if (errors + bus_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* cpu6502_lite.f */
common/cpu_isa_pkg.sv
common/cpu_uarch_pkg.sv
core/cpu_alu.sv
core/cpu_regs.sv
core/cpu_addr_unit.sv
core/cpu_sequencer.sv
design/cpu_top.sv
+incdir+bench
bench/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= cpu6502_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) bench/tb_cpu_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx "Simulation passed" $(LOG); then echo "Run ok"; else echo "Run not ok"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
